/* logic/segre_pkg.sv */
`default_nettype none

package segre_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int WORD_SIZE    = 32;    // core word and address width
    localparam int LANE_BYTES   = 16;    // cache line == memory lane
    localparam int DCACHE_LINES = 16;
    localparam int MEM_BYTES    = 4096;
    localparam int MEM_LATENCY  = 10;    // sampled rd to data_rdy, in cycles

    localparam int OFFSET_BITS  = $clog2(LANE_BYTES);
    localparam int INDEX_BITS   = $clog2(DCACHE_LINES);
    localparam int TAG_BITS     = WORD_SIZE - INDEX_BITS - OFFSET_BITS;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------
    typedef logic [WORD_SIZE-1:0]        word_t;
    typedef logic [WORD_SIZE-1:0]        addr_t;
    typedef logic [LANE_BYTES*8-1:0]     lane_t;
    typedef logic [WORD_SIZE/8-1:0]      sel_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [INDEX_BITS-1:0]       index_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        addr_t adr;
        word_t dat;     // write word
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;     // read word
    } wb_rsp_t;

    // cache controller to main memory
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;    // read lane address
        addr_t wr_addr; // write lane address
        lane_t data;
    } mem_req_t;

    typedef struct packed {
        logic  data_rdy;
        lane_t data;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        INSTALL,
        RESPOND
    } dcache_state_e;

endpackage

`default_nettype wire

/* logic/memory.sv */
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  segre_pkg::mem_req_t req_i,
    output segre_pkg::mem_rsp_t rsp_o
);

    import segre_pkg::*;

    logic [7:0] mem [MEM_BYTES];   // contents undefined until written

    logic [$clog2(MEM_BYTES)-1:0]   rd_base;
    logic [$clog2(MEM_BYTES)-1:0]   wr_base;
    lane_t                          rd_lane;
    logic                           busy;
    logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt;
    logic                           data_rdy;

    // upper address bits alias onto the 4 KB array
    assign rd_base = {req_i.addr[$clog2(MEM_BYTES)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign wr_base = {req_i.wr_addr[$clog2(MEM_BYTES)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int b = 0; b < LANE_BYTES; b++) begin
                mem[wr_base + b] <= req_i.data[8*b +: 8];
            end
        end
        // lane is taken before this edge's write lands
        if (req_i.rd) begin
            for (int b = 0; b < LANE_BYTES; b++) begin
                rd_lane[8*b +: 8] <= mem[rd_base + b];
            end
        end
    end

    // ----------------------------------------
    // read latency
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= 1'b0;   // single cycle pulse
            if (req_i.rd) begin
                busy    <= 1'b1;
                lat_cnt <= 1;
            end else if (busy) begin
                if (lat_cnt == MEM_LATENCY) begin
                    busy     <= 1'b0;
                    data_rdy <= 1'b1;
                end else begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
            end
        end
    end

    // read data stays put until the next read is sampled
    assign rsp_o.data_rdy = data_rdy;
    assign rsp_o.data     = rd_lane;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    rd_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i.rd |-> (req_i.addr[OFFSET_BITS-1:0] == '0));

    wr_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i.wr |-> (req_i.wr_addr[OFFSET_BITS-1:0] == '0));

    // the controller keeps one read in flight at most
    one_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i.rd |-> !busy);

endmodule

`default_nettype wire

/* logic/dcache_tags.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tags (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              lookup_i,
    input  segre_pkg::index_t index_i,
    input  logic              fill_i,
    input  segre_pkg::tag_t   fill_tag_i,
    input  logic              set_dirty_i,
    output segre_pkg::tag_t   tag_o,
    output logic              valid_o,
    output logic              dirty_o
);

    import segre_pkg::*;

    tag_t                    tag_mem [DCACHE_LINES];
    logic [DCACHE_LINES-1:0] valid;
    logic [DCACHE_LINES-1:0] dirty;

    // ----------------------------------------
    // tag storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_mem[index_i] <= fill_tag_i;
        end
        // a lookup in the fill cycle sees the new tag
        if (lookup_i) begin
            tag_o <= fill_i ? fill_tag_i : tag_mem[index_i];
        end
    end

    // ----------------------------------------
    // line state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid   <= '0;
            dirty   <= '0;
            valid_o <= 1'b0;
            dirty_o <= 1'b0;
        end else begin
            if (fill_i) begin
                valid[index_i] <= 1'b1;
                dirty[index_i] <= 1'b0;   // fresh from memory
            end else if (set_dirty_i) begin
                dirty[index_i] <= 1'b1;   // write hit
            end

            if (lookup_i) begin
                valid_o <= fill_i | valid[index_i];
                dirty_o <= !fill_i & dirty[index_i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_data.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data (
    input  logic              clk_i,
    input  logic              lookup_i,
    input  segre_pkg::index_t index_i,
    input  logic              fill_i,
    input  segre_pkg::lane_t  fill_lane_i,
    input  logic              merge_i,
    input  logic [1:0]        word_sel_i,
    input  segre_pkg::sel_t   sel_i,
    input  segre_pkg::word_t  word_i,
    output segre_pkg::lane_t  lane_o
);

    import segre_pkg::*;

    lane_t lane_mem [DCACHE_LINES];

    // ----------------------------------------
    // writes
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lane_mem[index_i] <= fill_lane_i;   // whole line on refill
        end else if (merge_i) begin
            for (int b = 0; b < WORD_SIZE/8; b++) begin
                if (sel_i[b]) begin
                    lane_mem[index_i][WORD_SIZE*word_sel_i + 8*b +: 8] <= word_i[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // registered read
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            // refill data goes straight through so the relookup hits
            lane_o <= fill_i ? fill_lane_i : lane_mem[index_i];
        end
    end

    // refill and write hit come from different controller states
    no_fill_merge: assert property (@(posedge clk_i)
        fill_i |-> !merge_i);

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // core side
    input  segre_pkg::wb_req_t  wb_req_i,
    output segre_pkg::wb_rsp_t  wb_rsp_o,
    // arrays
    output logic                lookup_o,
    output segre_pkg::index_t   index_o,
    output logic                fill_o,
    output segre_pkg::tag_t     fill_tag_o,
    output segre_pkg::lane_t    fill_lane_o,
    output logic                set_dirty_o,
    output logic                merge_o,
    output logic [1:0]          word_sel_o,
    output segre_pkg::sel_t     sel_o,
    output segre_pkg::word_t    word_o,
    input  segre_pkg::tag_t     tag_i,
    input  logic                valid_i,
    input  logic                dirty_i,
    input  segre_pkg::lane_t    lane_i,
    // main memory
    output segre_pkg::mem_req_t mem_req_o,
    input  segre_pkg::mem_rsp_t mem_rsp_i
);

    import segre_pkg::*;

    dcache_state_e state;
    dcache_state_e state_next;

    tag_t       req_tag;
    index_t     req_index;
    logic [1:0] req_word;
    logic       hit;

    // ----------------------------------------
    // address split
    // ----------------------------------------
    assign req_tag   = wb_req_i.adr[WORD_SIZE-1 -: TAG_BITS];
    assign req_index = wb_req_i.adr[OFFSET_BITS +: INDEX_BITS];
    assign req_word  = wb_req_i.adr[OFFSET_BITS-1:2];

    assign hit = valid_i && (tag_i == req_tag);

    // request fields are held by the master until ack
    assign index_o     = req_index;
    assign word_sel_o  = req_word;
    assign sel_o       = wb_req_i.sel;
    assign word_o      = wb_req_i.dat;
    assign fill_tag_o  = req_tag;
    assign fill_lane_o = mem_rsp_i.data;   // memory holds it past data_rdy

    assign wb_rsp_o.dat = lane_i[WORD_SIZE*req_word +: WORD_SIZE];

    // refill goes to the requested line, writeback to the victim
    assign mem_req_o.addr    = {req_tag, req_index, {OFFSET_BITS{1'b0}}};
    assign mem_req_o.wr_addr = {tag_i, req_index, {OFFSET_BITS{1'b0}}};
    assign mem_req_o.data    = lane_i;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next   = state;
        lookup_o     = 1'b0;
        fill_o       = 1'b0;
        set_dirty_o  = 1'b0;
        merge_o      = 1'b0;
        mem_req_o.rd = 1'b0;
        mem_req_o.wr = 1'b0;
        wb_rsp_o.ack = 1'b0;

        case (state)
            IDLE: begin
                if (wb_req_i.cyc && wb_req_i.stb) begin
                    lookup_o   = 1'b1;
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = RESPOND;
                end else begin
                    mem_req_o.rd = 1'b1;
                    mem_req_o.wr = valid_i && dirty_i;   // evict in the same cycle
                    state_next   = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp_i.data_rdy) begin
                    state_next = INSTALL;
                end
            end
            INSTALL: begin
                fill_o     = 1'b1;
                lookup_o   = 1'b1;   // relookup, hits through the bypass
                state_next = LOOKUP;
            end
            RESPOND: begin
                wb_rsp_o.ack = 1'b1;
                merge_o      = wb_req_i.we;
                set_dirty_o  = wb_req_i.we;
                state_next   = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // master holds cyc and stb from request until ack
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

/* logic/dcache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  segre_pkg::wb_req_t wb_req_i,
    output segre_pkg::wb_rsp_t wb_rsp_o
);

    import segre_pkg::*;

    // ----------------------------------------
    // array control and results
    // ----------------------------------------
    logic       lookup;
    index_t     index;
    logic       fill;
    tag_t       fill_tag;
    lane_t      fill_lane;
    logic       set_dirty;
    logic       merge;
    logic [1:0] word_sel;
    sel_t       sel;
    word_t      word;
    tag_t       tag;
    logic       valid;
    logic       dirty;
    lane_t      lane;

    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    dcache_ctrl u_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .lookup_o    (lookup),
        .index_o     (index),
        .fill_o      (fill),
        .fill_tag_o  (fill_tag),
        .fill_lane_o (fill_lane),
        .set_dirty_o (set_dirty),
        .merge_o     (merge),
        .word_sel_o  (word_sel),
        .sel_o       (sel),
        .word_o      (word),
        .tag_i       (tag),
        .valid_i     (valid),
        .dirty_i     (dirty),
        .lane_i      (lane),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    dcache_tags u_tags (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .lookup_i    (lookup),
        .index_i     (index),
        .fill_i      (fill),
        .fill_tag_i  (fill_tag),
        .set_dirty_i (set_dirty),
        .tag_o       (tag),
        .valid_o     (valid),
        .dirty_o     (dirty)
    );

    dcache_data u_data (
        .clk_i       (clk_i),
        .lookup_i    (lookup),
        .index_i     (index),
        .fill_i      (fill),
        .fill_lane_i (fill_lane),
        .merge_i     (merge),
        .word_sel_i  (word_sel),
        .sel_i       (sel),
        .word_i      (word),
        .lane_o      (lane)
    );

    memory u_memory (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp)
    );

endmodule

`default_nettype wire

/* verification/clk_rst_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam real PERIOD_NS    = 8.0;
    localparam int  RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset held from time zero, released away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/dcache_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem_tb;

    import segre_pkg::*;

    // ----------------------------------------
    // run length
    // ----------------------------------------
    localparam int RANDOM_OPS     = 200;
    localparam int PRELOAD_OPS    = 64;
    localparam int NUM_OPS        = 2 + 4 + 3 + PRELOAD_OPS + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (MEM_LATENCY + 8) + 100;

    logic    clk_i;
    logic    arst_n_i;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    word_t   ref_mem [1024];   // expected word per 4 KB word address
    integer  seed = 32'hbad3_6b65;
    int      cycle_count = 0;

    clk_rst_gen u_clk_rst (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    dcache_subsystem UUT (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    // ----------------------------------------
    // failure handling
    // ----------------------------------------
    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run timed out waiting for ack after %0d cycles", cycle_count);
            stop_run();
        end
    end

    // ----------------------------------------
    // bus helpers, entered and left on a falling edge
    // ----------------------------------------
    task automatic wb_cycle(input logic we, input sel_t sel, input addr_t adr,
                            input word_t dat, output word_t rdata, output int cycles);
        cycles     = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.sel = sel;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat;
        @(negedge clk_i);   // hold through the edge that ends the ack cycle
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input addr_t adr, input sel_t sel, input word_t dat,
                            output int cycles);
        word_t unused;
        wb_cycle(1'b1, sel, adr, dat, unused, cycles);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) ref_mem[adr[11:2]][8*b +: 8] = dat[8*b +: 8];
        end
    endtask

    task automatic wb_read(input addr_t adr, output word_t data, output int cycles);
        wb_cycle(1'b0, 4'h0, adr, '0, data, cycles);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset();
        // bus stays idle here, so no ack may appear
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_i);
            check("reset ack", 32'd0, {31'd0, wb_rsp.ack});
        end
    endtask

    task automatic test_write_read();
        word_t data;
        int    cycles;
        wb_write(32'h010, 4'hf, 32'hcafe_0123, cycles);
        if (cycles < MEM_LATENCY + 3) begin
            $display("write miss acknowledged after %0d cycles, too early for a refill", cycles);
            stop_run();
        end
        wb_read(32'h010, data, cycles);
        check("write_read data", ref_mem[10'h004], data);
        check("write_read latency", 32'd2, cycles);
    endtask

    task automatic test_byte_select();
        word_t data;
        int    cycles;
        wb_write(32'h024, 4'hf, 32'h1122_3344, cycles);
        wb_write(32'h024, 4'b0001, 32'haaaa_aaaa, cycles);
        wb_write(32'h024, 4'b0100, 32'hbbbb_bbbb, cycles);
        wb_read(32'h024, data, cycles);
        check("byte_select", ref_mem[10'h009], data);
    endtask

    task automatic test_eviction();
        word_t data;
        int    cycles;
        // same index, tags differ by one
        wb_write(32'h048, 4'hf, 32'h0bad_f00d, cycles);
        wb_write(32'h148, 4'hf, 32'h5eed_1234, cycles);
        wb_read(32'h048, data, cycles);
        check("eviction", ref_mem[10'h012], data);
        if (cycles < MEM_LATENCY + 3) begin
            $display("eviction read acknowledged after %0d cycles, before a refill", cycles);
            stop_run();
        end
    endtask

    function automatic addr_t region_addr(input logic [5:0] w);
        // four regions 256 bytes apart, each covering lines 0 to 3
        return {20'd0, 2'b10, w[5:4], 2'b00, w[3:0], 2'b00};
    endfunction

    task automatic test_random_traffic();
        logic [31:0] r;
        addr_t       adr;
        word_t       data;
        int          cycles;
        for (int w = 0; w < PRELOAD_OPS; w++) begin
            wb_write(region_addr(w[5:0]), 4'hf, $random(seed), cycles);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r   = $random(seed);
            adr = region_addr(r[5:0]);
            if (r[8]) begin
                wb_write(adr, r[15:12], $random(seed), cycles);
            end else begin
                wb_read(adr, data, cycles);
                check("random_traffic", ref_mem[adr[11:2]], data);
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        wb_req = '0;
        @(posedge arst_n_i);
        test_reset();
        test_write_read();
        test_byte_select();
        test_eviction();
        test_random_traffic();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
logic/segre_pkg.sv
logic/memory.sv
logic/dcache_tags.sv
logic/dcache_data.sv
logic/dcache_ctrl.sv
logic/dcache_subsystem.sv
verification/clk_rst_gen.sv
verification/dcache_subsystem_tb.sv
